//--- project.f
source/noc_pkg.sv
source/noc_input_buffer.sv
source/noc_output_arbiter.sv
source/noc_router.sv
source/noc_mesh.sv
tb/noc_clock_gen.sv
tb/noc_mesh_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the mesh NoC testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module noc_mesh_tb -o noc_mesh_sim &&
./obj_dir/noc_mesh_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- source/noc_input_buffer.sv
// circular FIFO on one router input port; valid/ready on both sides, one cycle latency
`timescale 1ns/1ns

module noc_input_buffer import noc_pkg::*; #(
   parameter int depth = 4
) (
   input  logic  clk,
   input  logic  rst_n,
   input  flit_t in_flit,
   input  logic  in_valid,
   output logic  in_ready,
   output flit_t out_flit,
   output logic  out_valid,
   input  logic  out_ready
);

   localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
   localparam int count_width = $clog2(depth + 1);

   flit_t                  mem [depth];
   logic [ptr_width-1:0]   wr_ptr;
   logic [ptr_width-1:0]   rd_ptr;
   logic [count_width-1:0] count;
   logic                   push;
   logic                   pop;

   // step to the next slot and wrap back to zero after the top one
   function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
      if (ptr == ptr_width'(depth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign in_ready  = (count != count_width'(depth));
   assign out_valid = (count != '0);
   assign out_flit  = mem[rd_ptr];

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_flit;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         // simultaneous push and pop leaves the fill level alone
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   a_count_bound: assert property (
      @(posedge clk) disable iff (!rst_n) count <= count_width'(depth)
   ) else $error("input buffer holds more flits than its depth");

endmodule

//--- source/noc_mesh.sv
// top level of the mesh NoC; builds the router grid and links neighbours, one local port per node
`timescale 1ns/1ns

module noc_mesh import noc_pkg::*; #(
   parameter int x_dim        = 3,
   parameter int y_dim        = 2,
   parameter int buffer_depth = 4
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  flit_t [x_dim*y_dim-1:0]     in_flit,
   input  logic  [x_dim*y_dim-1:0]     in_valid,
   output logic  [x_dim*y_dim-1:0]     in_ready,
   output flit_t [x_dim*y_dim-1:0]     out_flit,
   output logic  [x_dim*y_dim-1:0]     out_valid,
   input  logic  [x_dim*y_dim-1:0]     out_ready
);

   localparam int nodes = x_dim * y_dim;

   // per-node wiring indexed by port
   flit_t [4:0] node_in_flit   [nodes];
   logic  [4:0] node_in_valid  [nodes];
   logic  [4:0] node_in_ready  [nodes];
   flit_t [4:0] node_out_flit  [nodes];
   logic  [4:0] node_out_valid [nodes];
   logic  [4:0] node_out_ready [nodes];

   for (genvar y = 0; y < y_dim; y++) begin : gen_y
      for (genvar x = 0; x < x_dim; x++) begin : gen_x
         localparam int n = x + y * x_dim;

         noc_router #(
            .x_dim        (x_dim),
            .y_dim        (y_dim),
            .x_pos        (x),
            .y_pos        (y),
            .buffer_depth (buffer_depth)
         ) u_router (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_flit   (node_in_flit[n]),
            .in_valid  (node_in_valid[n]),
            .in_ready  (node_in_ready[n]),
            .out_flit  (node_out_flit[n]),
            .out_valid (node_out_valid[n]),
            .out_ready (node_out_ready[n])
         );

         // injection and ejection
         assign node_in_flit[n][port_local]   = in_flit[n];
         assign node_in_valid[n][port_local]  = in_valid[n];
         assign in_ready[n]                   = node_in_ready[n][port_local];
         assign out_flit[n]                   = node_out_flit[n][port_local];
         assign out_valid[n]                  = node_out_valid[n][port_local];
         assign node_out_ready[n][port_local] = out_ready[n];

         // neighbour links and the idle tie-offs on the grid edge
         if (y > 0) begin : gen_south
            assign node_in_flit[n][port_south]   = node_out_flit[n - x_dim][port_north];
            assign node_in_valid[n][port_south]  = node_out_valid[n - x_dim][port_north];
            assign node_out_ready[n][port_south] = node_in_ready[n - x_dim][port_north];
         end else begin : gen_south_edge
            assign node_in_flit[n][port_south]   = '0;
            assign node_in_valid[n][port_south]  = 1'b0;
            assign node_out_ready[n][port_south] = 1'b0;
         end

         if (y < y_dim - 1) begin : gen_north
            assign node_in_flit[n][port_north]   = node_out_flit[n + x_dim][port_south];
            assign node_in_valid[n][port_north]  = node_out_valid[n + x_dim][port_south];
            assign node_out_ready[n][port_north] = node_in_ready[n + x_dim][port_south];
         end else begin : gen_north_edge
            assign node_in_flit[n][port_north]   = '0;
            assign node_in_valid[n][port_north]  = 1'b0;
            assign node_out_ready[n][port_north] = 1'b0;
         end

         if (x > 0) begin : gen_west
            assign node_in_flit[n][port_west]   = node_out_flit[n - 1][port_east];
            assign node_in_valid[n][port_west]  = node_out_valid[n - 1][port_east];
            assign node_out_ready[n][port_west] = node_in_ready[n - 1][port_east];
         end else begin : gen_west_edge
            assign node_in_flit[n][port_west]   = '0;
            assign node_in_valid[n][port_west]  = 1'b0;
            assign node_out_ready[n][port_west] = 1'b0;
         end

         if (x < x_dim - 1) begin : gen_east
            assign node_in_flit[n][port_east]   = node_out_flit[n + 1][port_west];
            assign node_in_valid[n][port_east]  = node_out_valid[n + 1][port_west];
            assign node_out_ready[n][port_east] = node_in_ready[n + 1][port_west];
         end else begin : gen_east_edge
            assign node_in_flit[n][port_east]   = '0;
            assign node_in_valid[n][port_east]  = 1'b0;
            assign node_out_ready[n][port_east] = 1'b0;
         end
      end
   end

endmodule

//--- source/noc_output_arbiter.sv
// round-robin arbiter for one router output; grant stays locked until the last flit passes
`timescale 1ns/1ns

module noc_output_arbiter (
   input  logic       clk,
   input  logic       rst_n,
   input  logic [4:0] request,
   input  logic [4:0] last,
   input  logic       out_ready,
   output logic [4:0] grant,
   output logic       active
);

   logic [4:0] locked_grant;
   logic       locked;
   logic [2:0] last_winner;
   logic [4:0] pick;
   logic [2:0] pick_idx;
   logic       fire;
   logic       fire_last;

   // search starts one past the previous winner
   always_comb begin
      int idx;
      pick     = '0;
      pick_idx = last_winner;
      for (int k = 1; k <= 5; k++) begin
         idx = (int'(last_winner) + k) % 5;
         if (request[idx] && pick == '0) begin
            pick[idx] = 1'b1;
            pick_idx  = 3'(idx);
         end
      end
   end

   assign grant  = locked ? locked_grant : pick;
   assign active = |grant;

   // a flit leaves when the granted input has one and downstream takes it
   assign fire      = out_ready && |(grant & request);
   assign fire_last = fire && |(grant & last);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         locked       <= 1'b0;
         locked_grant <= '0;
         last_winner  <= 3'd4;
      end else if (locked) begin
         if (fire_last) begin
            locked <= 1'b0;
         end
      end else if (|pick) begin
         // lock at once so the offered flit stays put while stalled,
         // except for a single-flit packet that already left
         locked       <= !fire_last;
         locked_grant <= pick;
         last_winner  <= pick_idx;
      end
   end

   a_grant_onehot: assert property (
      @(posedge clk) disable iff (!rst_n) $onehot0(grant)
   ) else $error("output grant is not one-hot");

endmodule

//--- source/noc_pkg.sv
// flit types, port indices and id widths shared by every mesh NoC module; import with noc_pkg::*
package noc_pkg;

   // width of one flit word on a link
   localparam int flit_width = 32;

   // node numbers are x + y * x_dim
   localparam int node_id_width = 8;

   // indices into the five port arrays of a router
   // port k of a router faces the opposite port of its neighbour
   localparam int port_local = 0;
   localparam int port_north = 1;
   localparam int port_east  = 2;
   localparam int port_south = 3;
   localparam int port_west  = 4;

   // head flit layout
   typedef struct packed {
      logic [node_id_width-1:0]              dest;
      logic [node_id_width-1:0]              src;
      logic [flit_width-2*node_id_width-1:0] tag;
   } noc_header_t;

   // the head flit is read as a header, every later flit as raw data
   typedef union packed {
      noc_header_t           header;
      logic [flit_width-1:0] data;
   } flit_word_t;

   // what travels on each link and through each buffer
   typedef struct packed {
      logic       last;
      flit_word_t word;
   } flit_t;

endpackage

//--- source/noc_router.sv
// five-port wormhole router with input FIFOs, XY routing and per-output arbiters; one per mesh node
`timescale 1ns/1ns

module noc_router import noc_pkg::*; #(
   parameter int x_dim        = 3,
   parameter int y_dim        = 2,
   parameter int x_pos        = 0,
   parameter int y_pos        = 0,
   parameter int buffer_depth = 4
) (
   input  logic        clk,
   input  logic        rst_n,
   input  flit_t [4:0] in_flit,
   input  logic  [4:0] in_valid,
   output logic  [4:0] in_ready,
   output flit_t [4:0] out_flit,
   output logic  [4:0] out_valid,
   input  logic  [4:0] out_ready
);

   // ports that face the edge of the grid
   localparam logic [4:0] border_mask =
      ((y_pos == y_dim - 1) ? (5'b1 << port_north) : 5'b0) |
      ((x_pos == x_dim - 1) ? (5'b1 << port_east)  : 5'b0) |
      ((y_pos == 0)         ? (5'b1 << port_south) : 5'b0) |
      ((x_pos == 0)         ? (5'b1 << port_west)  : 5'b0);

   flit_t      buf_flit [5];
   logic [4:0] buf_valid;
   logic [4:0] buf_ready;
   logic [4:0] buf_last;

   // one-hot output choice of each input
   logic [4:0] route [5];

   // req and gnt hold one bit per input for each output
   logic [4:0] req [5];
   logic [4:0] gnt [5];
   logic       active [5];

   for (genvar i = 0; i < 5; i++) begin : gen_input
      logic       busy;
      logic [4:0] route_q;

      noc_input_buffer #(
         .depth (buffer_depth)
      ) u_buffer (
         .clk       (clk),
         .rst_n     (rst_n),
         .in_flit   (in_flit[i]),
         .in_valid  (in_valid[i]),
         .in_ready  (in_ready[i]),
         .out_flit  (buf_flit[i]),
         .out_valid (buf_valid[i]),
         .out_ready (buf_ready[i])
      );

      assign buf_last[i] = buf_flit[i].last;

      // XY order settles the column first and then the row
      always_comb begin
         noc_header_t head;
         int          dest_x;
         int          dest_y;
         head   = buf_flit[i].word.header;
         dest_x = int'(head.dest) % x_dim;
         dest_y = int'(head.dest) / x_dim;
         if (busy) begin
            route[i] = route_q;
         end else if (dest_x > x_pos) begin
            route[i] = 5'b1 << port_east;
         end else if (dest_x < x_pos) begin
            route[i] = 5'b1 << port_west;
         end else if (dest_y > y_pos) begin
            route[i] = 5'b1 << port_north;
         end else if (dest_y < y_pos) begin
            route[i] = 5'b1 << port_south;
         end else begin
            route[i] = 5'b1 << port_local;
         end
      end

      // remember the head's direction for the body of the packet
      always_ff @(posedge clk) begin
         if (!rst_n) begin
            busy <= 1'b0;
         end else if (buf_valid[i] && buf_ready[i]) begin
            busy <= !buf_last[i];
         end
      end

      always_ff @(posedge clk) begin
         if (buf_valid[i] && buf_ready[i] && !busy) begin
            route_q <= route[i];
         end
      end

      a_no_border_route: assert property (
         @(posedge clk) disable iff (!rst_n) buf_valid[i] |-> (route[i] & border_mask) == '0
      ) else $error("route leaves the grid at router (%0d,%0d)", x_pos, y_pos);
   end

   for (genvar o = 0; o < 5; o++) begin : gen_output
      noc_output_arbiter u_arbiter (
         .clk       (clk),
         .rst_n     (rst_n),
         .request   (req[o]),
         .last      (buf_last),
         .out_ready (out_ready[o]),
         .grant     (gnt[o]),
         .active    (active[o])
      );
   end

   always_comb begin
      for (int o = 0; o < 5; o++) begin
         for (int i = 0; i < 5; i++) begin
            req[o][i] = buf_valid[i] && route[i][o];
         end
      end
   end

   // each output forwards its granted input and returns ready only to it
   always_comb begin
      buf_ready = '0;
      for (int o = 0; o < 5; o++) begin
         out_flit[o] = '0;
         for (int i = 0; i < 5; i++) begin
            if (gnt[o][i]) begin
               out_flit[o] = buf_flit[i];
            end
            buf_ready[i] = buf_ready[i] | (gnt[o][i] & out_ready[o]);
         end
         out_valid[o] = active[o] && |(gnt[o] & buf_valid);
      end
   end

endmodule

//--- tb/noc_clock_gen.sv
// clock and reset source for the mesh NoC testbench; 40 ns clock, reset held low for 3 cycles
`timescale 1ns/1ns

module noc_clock_gen #(
   parameter int period       = 40,
   parameter int reset_cycles = 3
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // release just after an edge like every other testbench input
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #2;
      rst_n = 1'b1;
   end

endmodule

//--- tb/noc_mesh_tb.sv
// directed tests for the 3x2 mesh NoC; run as top module with the clock generator and the DUT
`timescale 1ns/1ns

module noc_mesh_tb import noc_pkg::*; ();

   localparam int x_dim          = 3;
   localparam int y_dim          = 2;
   localparam int nodes          = x_dim * y_dim;
   localparam int random_packets = 40;
   // all pairs, long packet, back-pressure, two converging packets, random worst case
   localparam int total_flits    = nodes * nodes + 5 + 20 + 2 * 6 + 4 * random_packets;
   localparam int timeout_cycles = total_flits * 40 + 200;

   logic                   clk;
   logic                   rst_n;
   flit_t [nodes-1:0]      in_flit;
   logic  [nodes-1:0]      in_valid;
   logic  [nodes-1:0]      in_ready;
   flit_t [nodes-1:0]      out_flit;
   logic  [nodes-1:0]      out_valid;
   logic  [nodes-1:0]      out_ready;

   // expected flits in one queue per source and destination pair
   flit_t       exp_q [nodes*nodes][$];
   logic        in_pkt [nodes];
   int          cur_src [nodes];
   int          sent_count  = 0;
   int          recv_count  = 0;
   int          cycle_count = 0;
   logic [31:0] rng_state   = 32'd16691;

   noc_clock_gen u_clock_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   noc_mesh #(
      .x_dim        (x_dim),
      .y_dim        (y_dim),
      .buffer_depth (4)
   ) DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_flit   (in_flit),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .out_flit  (out_flit),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] next_seed();
      rng_state = lcg_step(rng_state);
      return rng_state;
   endfunction

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("ERR %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // called at posedge+2; returns at posedge+2 after the handshake edge
   task automatic wait_accept(input int src);
      @(negedge clk);
      while (!in_ready[src]) @(negedge clk);
      @(posedge clk);
      #2;
   endtask

   // header first, then payload words from a private LCG stream
   task automatic send_packet(input int src, input int dest, input int len,
                              input logic [31:0] seed);
      flit_t       pkt [$];
      flit_t       f;
      logic [31:0] rng;
      rng = seed;
      for (int k = 0; k < len; k++) begin
         rng = lcg_step(rng);
         f.last = (k == len - 1);
         if (k == 0) begin
            f.word.header.dest = node_id_width'(dest);
            f.word.header.src  = node_id_width'(src);
            f.word.header.tag  = rng[31:16];
         end else begin
            f.word.data = rng;
         end
         pkt.push_back(f);
         exp_q[src * nodes + dest].push_back(f);
         sent_count++;
      end
      foreach (pkt[k]) begin
         in_flit[src]  = pkt[k];
         in_valid[src] = 1'b1;
         wait_accept(src);
      end
      in_valid[src] = 1'b0;
   endtask

   task automatic check_ejected(input int node, input flit_t got);
      int    src;
      int    key;
      flit_t want;
      if (!in_pkt[node]) begin
         // a head flit names its source and must be addressed here
         check_value(64'(got.word.header.dest), 64'(node), "head flit destination");
         check_value(64'(got.word.header.src < node_id_width'(nodes)), 64'(1),
                     "head flit source in range");
         cur_src[node] = int'(got.word.header.src);
      end
      src = cur_src[node];
      key = src * nodes + node;
      check_value(64'(exp_q[key].size() != 0), 64'(1), "flit expected for this pair");
      want = exp_q[key].pop_front();
      check_value(64'(got), 64'(want), $sformatf("flit from node %0d at node %0d", src, node));
      in_pkt[node] = !got.last;
      recv_count++;
   endtask

   // outputs are stable mid-cycle and the handshake completes on the next edge
   for (genvar n = 0; n < nodes; n++) begin : gen_monitor
      always @(negedge clk) begin
         if (rst_n && out_valid[n] && out_ready[n]) begin
            check_ejected(n, out_flit[n]);
         end
      end
   end

   always @(posedge clk) begin
      if (rst_n) begin
         cycle_count <= cycle_count + 1;
         if (cycle_count >= timeout_cycles) begin
            $display("run timed out waiting for flits after %0d cycles", cycle_count);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
         end
      end
   end

   task automatic wait_for_delivery();
      while (recv_count != sent_count) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic test_reset_state();
      @(negedge clk);
      check_value(64'(out_valid), 64'(0), "out_valid after reset");
      check_value(64'(in_ready), 64'({nodes{1'b1}}), "in_ready after reset");
      @(posedge clk);
      #2;
   endtask

   task automatic test_all_pairs();
      for (int s = 0; s < nodes; s++) begin
         for (int d = 0; d < nodes; d++) begin
            send_packet(s, d, 1, next_seed());
         end
      end
      wait_for_delivery();
   endtask

   task automatic test_long_packet();
      send_packet(1, 3, 5, next_seed());
      wait_for_delivery();
   endtask

   // node 0 to node 5 crosses four buffers, so 20 flits back up to the source
   task automatic test_backpressure();
      logic        saw_full;
      logic [31:0] seed;
      saw_full     = 1'b0;
      seed         = next_seed();
      out_ready[5] = 1'b0;
      fork
         send_packet(0, 5, 20, seed);
         begin
            repeat (30) begin
               @(negedge clk);
               if (!in_ready[0]) begin
                  saw_full = 1'b1;
               end
            end
            @(posedge clk);
            #2;
            out_ready[5] = 1'b1;
         end
      join
      check_value(64'(saw_full), 64'(1), "source in_ready dropped under back-pressure");
      wait_for_delivery();
   endtask

   // both packets meet at the north output of router 1
   task automatic test_converging_packets();
      logic [31:0] seed_a;
      logic [31:0] seed_b;
      seed_a = next_seed();
      seed_b = next_seed();
      fork
         send_packet(0, 4, 6, seed_a);
         send_packet(2, 4, 6, seed_b);
      join
      wait_for_delivery();
   endtask

   task automatic test_random_traffic();
      logic [31:0] r;
      logic [31:0] stall_rng;
      logic        done;
      logic        stop;
      int          src;
      int          dest;
      int          len;
      done      = 1'b0;
      stop      = 1'b0;
      stall_rng = next_seed();
      fork
         begin
            for (int p = 0; p < random_packets; p++) begin
               r    = next_seed();
               src  = int'(r[31:16]) % nodes;
               r    = next_seed();
               dest = int'(r[31:16]) % nodes;
               r    = next_seed();
               len  = int'(r[31:16]) % 4 + 1;
               send_packet(src, dest, len, next_seed());
            end
            done = 1'b1;
         end
         begin
            while (!stop) begin
               stall_rng = lcg_step(stall_rng);
               // about one cycle in four stalls each ejection port
               for (int n = 0; n < nodes; n++) begin
                  out_ready[n] = (stall_rng[16 + 2 * n +: 2] != 2'b00);
               end
               @(negedge clk);
               stop = done;
               @(posedge clk);
               #2;
            end
            out_ready = '1;
         end
      join
      wait_for_delivery();
   endtask

   task automatic check_queues_empty();
      for (int k = 0; k < nodes * nodes; k++) begin
         check_value(64'(exp_q[k].size()), 64'(0), $sformatf("flits left for pair %0d", k));
      end
   endtask

   initial begin
      in_flit   = '0;
      in_valid  = '0;
      out_ready = '1;
      for (int n = 0; n < nodes; n++) begin
         in_pkt[n]  = 1'b0;
         cur_src[n] = 0;
      end
      wait (rst_n === 1'b1);
      @(posedge clk);
      #2;
      test_reset_state();
      test_all_pairs();
      test_long_packet();
      test_backpressure();
      test_converging_packets();
      test_random_traffic();
      check_queues_empty();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
